/* Bender.yml */
package:
  name: lut_unit

sources:
  - files:
      - hw/lut_pkg.sv
      - hw/lut_addr_gen.sv
      - hw/lut_mem_writer.sv
      - hw/lut_dp_ram.sv
      - hw/lut_read_unit.sv
      - hw/lut_apb_regs.sv
      - hw/lut_top.sv
  - target: simulation
    files:
      - verif/lut_bus_model.sv
      - verif/lut_tb.sv

/* hw/lut_addr_gen.sv */
`default_nettype none

module lut_addr_gen #(
   parameter int ADDR_W = 8
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  run,
   input  wire [ADDR_W-1:0]     iterations,
   input  lut_pkg::period_t     period,
   input  lut_pkg::period_t     duty,
   input  wire [ADDR_W-1:0]     shift,
   input  wire [ADDR_W-1:0]     incr,
   input  wire                  ready,
   output logic                 valid,
   output logic [ADDR_W-1:0]    addr,
   output logic                 done
);

   import lut_pkg::*;

   gen_state_t        state;
   logic [ADDR_W-1:0] row;
   period_t           step;
   logic              last_step;
   logic              last_row;
   logic              advance;

   // Steps at or past duty are gaps with no address
   assign valid     = (state == RUN) && (step < duty);
   assign last_step = (step == period - 10'd1);
   assign last_row  = (row == iterations - 1'b1);

   // A gap step always moves on, an emitted one waits for ready
   assign advance = (state == RUN) && (!valid || ready);

   assign done = (state == DONE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
         row   <= '0;
         step  <= '0;
         addr  <= '0;
      end else if (run) begin
         row  <= '0;
         step <= '0;
         addr <= '0;
         // Nothing to walk for an empty pattern
         if (iterations == '0 || period == '0) begin
            state <= DONE;
         end else begin
            state <= RUN;
         end
      end else if (advance) begin
         if (last_step) begin
            addr <= addr + incr + shift;
            step <= '0;
            row  <= row + 1'b1;
            if (last_row) begin
               state <= DONE;
            end
         end else begin
            addr <= addr + incr;
            step <= step + 10'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/lut_apb_regs.sv */
`default_nettype none

module lut_apb_regs #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  wire                  clk,
   input  wire                  rst,
   // APB slave
   input  wire                  psel,
   input  wire                  penable,
   input  wire                  pwrite,
   input  wire [7:0]            paddr,
   input  wire [DATA_W-1:0]     pwdata,
   output logic [DATA_W-1:0]    prdata,
   output logic                 pready,
   output logic                 pslverr,
   // Status in
   input  wire                  done,
   // Configuration out
   output logic                 run,
   output logic                 ping_pong,
   output lut_pkg::io_addr_t    ext_addr,
   output lut_pkg::burst_len_t  length,
   output logic [ADDR_W-1:0]    iterations,
   output lut_pkg::period_t     period,
   output lut_pkg::period_t     duty,
   output logic [ADDR_W-1:0]    shift,
   output logic [ADDR_W-1:0]    incr
);

   import lut_pkg::*;

   logic addr_ok;
   logic wr_access;

   always_comb begin
      case (paddr)
         REG_CTRL, REG_STATUS, REG_EXT_ADDR, REG_ITER, REG_PER,
         REG_DUTY, REG_SHIFT, REG_INCR, REG_LENGTH: addr_ok = 1'b1;
         default: addr_ok = 1'b0;
      endcase
   end

   assign pready    = 1'b1;
   assign pslverr   = psel && penable && !addr_ok;
   assign wr_access = psel && penable && pwrite && addr_ok;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run        <= 1'b0;
         ping_pong  <= 1'b0;
         ext_addr   <= '0;
         length     <= '0;
         iterations <= '0;
         period     <= '0;
         duty       <= '0;
         shift      <= '0;
         incr       <= '0;
      end else begin
         // Run is a single-cycle strobe
         run <= wr_access && (paddr == REG_CTRL) && pwdata[CTRL_RUN_BIT];
         if (wr_access) begin
            case (paddr)
               REG_CTRL:     ping_pong  <= pwdata[CTRL_PING_BIT];
               REG_EXT_ADDR: ext_addr   <= pwdata[31:0];
               REG_ITER:     iterations <= pwdata[ADDR_W-1:0];
               REG_PER:      period     <= pwdata[9:0];
               REG_DUTY:     duty       <= pwdata[9:0];
               REG_SHIFT:    shift      <= pwdata[ADDR_W-1:0];
               REG_INCR:     incr       <= pwdata[ADDR_W-1:0];
               REG_LENGTH:   length     <= pwdata[7:0];
               default:      ;
            endcase
         end
      end
   end

   always_comb begin
      prdata = '0;
      case (paddr)
         REG_CTRL:     prdata[CTRL_PING_BIT] = ping_pong;
         REG_STATUS:   prdata[0]             = done;
         REG_EXT_ADDR: prdata[31:0]          = ext_addr;
         REG_ITER:     prdata[ADDR_W-1:0]    = iterations;
         REG_PER:      prdata[9:0]           = period;
         REG_DUTY:     prdata[9:0]           = duty;
         REG_SHIFT:    prdata[ADDR_W-1:0]    = shift;
         REG_INCR:     prdata[ADDR_W-1:0]    = incr;
         REG_LENGTH:   prdata[7:0]           = length;
         default:      prdata                = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/lut_dp_ram.sv */
`default_nettype none

module lut_dp_ram #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  wire                  clk,
   input  wire [ADDR_W-1:0]     rd_addr,
   input  wire                  wr_en,
   input  wire [ADDR_W-1:0]     wr_addr,
   input  wire [DATA_W-1:0]     wr_data,
   output logic [DATA_W-1:0]    rd_data
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Same-cycle collision returns the old word
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

/* hw/lut_mem_writer.sv */
`default_nettype none

module lut_mem_writer #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  run,
   // Address side
   input  wire                  gen_valid,
   output logic                 gen_ready,
   input  wire [ADDR_W-1:0]     gen_addr,
   // Data side
   input  wire                  data_valid,
   output logic                 data_ready,
   input  wire [DATA_W-1:0]     data_in,
   // Table write port
   output logic                 mem_enable,
   output logic [ADDR_W-1:0]    mem_addr,
   output logic [DATA_W-1:0]    mem_data,
   output lut_pkg::burst_len_t  beat_cnt
);

   // Each side waits on the other so address and beat move together
   assign gen_ready  = data_valid;
   assign data_ready = gen_valid;

   assign mem_enable = gen_valid && data_valid;
   assign mem_addr   = gen_addr;
   assign mem_data   = data_in;

   // Beats written since the last run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         beat_cnt <= '0;
      end else if (run) begin
         beat_cnt <= '0;
      end else if (mem_enable) begin
         beat_cnt <= beat_cnt + 8'd1;
      end
   end

endmodule

`default_nettype wire

/* hw/lut_pkg.sv */
`default_nettype none

package lut_pkg;

   // External bus byte address
   typedef logic [31:0] io_addr_t;

   // Period and duty counts of the address generator
   typedef logic [9:0] period_t;

   // Beats in one bus burst
   typedef logic [7:0] burst_len_t;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DONE
   } gen_state_t;

   // APB register map
   localparam logic [7:0] REG_CTRL     = 8'h00;
   localparam logic [7:0] REG_STATUS   = 8'h04;
   localparam logic [7:0] REG_EXT_ADDR = 8'h08;
   localparam logic [7:0] REG_ITER     = 8'h0C;
   localparam logic [7:0] REG_PER      = 8'h10;
   localparam logic [7:0] REG_DUTY     = 8'h14;
   localparam logic [7:0] REG_SHIFT    = 8'h18;
   localparam logic [7:0] REG_INCR     = 8'h1C;
   localparam logic [7:0] REG_LENGTH   = 8'h20;

   // Control register bits
   localparam int CTRL_RUN_BIT  = 0;
   localparam int CTRL_PING_BIT = 1;

endpackage

`default_nettype wire

/* hw/lut_read_unit.sv */
`default_nettype none

module lut_read_unit #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  run,
   input  wire                  ping_pong,
   // Load configuration
   input  lut_pkg::io_addr_t    ext_addr,
   input  lut_pkg::burst_len_t  length,
   input  wire [ADDR_W-1:0]     iterations,
   input  lut_pkg::period_t     period,
   input  lut_pkg::period_t     duty,
   input  wire [ADDR_W-1:0]     shift,
   input  wire [ADDR_W-1:0]     incr,
   // Lookup key
   input  wire [ADDR_W-1:0]     key,
   // External data bus
   output logic                 bus_valid,
   output lut_pkg::io_addr_t    bus_addr,
   output lut_pkg::burst_len_t  bus_len,
   input  wire [DATA_W-1:0]     bus_rdata,
   input  wire                  bus_ready,
   input  wire                  bus_last,
   // Table memory ports
   output logic [ADDR_W-1:0]    rd_addr,
   output logic [ADDR_W-1:0]    wr_addr,
   output logic                 wr_en,
   output logic [DATA_W-1:0]    wr_data,
   output logic                 done
);

   import lut_pkg::*;

   logic              bank;
   logic              gen_valid;
   logic              gen_ready;
   logic [ADDR_W-1:0] gen_addr;
   logic              gen_done;
   logic [ADDR_W-1:0] mem_addr;
   burst_len_t        beat_cnt;
   logic              last_beat;

   assign bus_len = length;

   // Lookup side reads the live bank
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
      end else begin
         rd_addr <= {bank ^ key[ADDR_W-1], key[ADDR_W-2:0]};
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank     <= 1'b0;
         bus_addr <= '0;
      end else if (run) begin
         bank     <= ping_pong ? !bank : 1'b0;
         bus_addr <= ext_addr;
      end
   end

   // Final beat flagged by the bus or by the local count
   assign last_beat = bus_last || (beat_cnt == length - 8'd1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done <= 1'b1;
      end else if (run) begin
         done <= 1'b0;
      end else if (wr_en && last_beat) begin
         done <= 1'b1;
      end else if (gen_done && length == '0) begin
         // Zero-length load never sees a beat
         done <= 1'b1;
      end
   end

   lut_addr_gen #(
      .ADDR_W(ADDR_W)
   ) u_addr_gen (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .iterations(iterations),
      .period    (period),
      .duty      (duty),
      .shift     (shift),
      .incr      (incr),
      .ready     (gen_ready),
      .valid     (gen_valid),
      .addr      (gen_addr),
      .done      (gen_done)
   );

   lut_mem_writer #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_mem_writer (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .gen_valid (gen_valid),
      .gen_ready (gen_ready),
      .gen_addr  (gen_addr),
      .data_valid(bus_ready),
      .data_ready(bus_valid),
      .data_in   (bus_rdata),
      .mem_enable(wr_en),
      .mem_addr  (mem_addr),
      .mem_data  (wr_data),
      .beat_cnt  (beat_cnt)
   );

   // Loads land in the idle bank
   assign wr_addr = {!bank ^ mem_addr[ADDR_W-1], mem_addr[ADDR_W-2:0]};

endmodule

`default_nettype wire

/* hw/lut_top.sv */
`default_nettype none

module lut_top #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 8
) (
   input  wire                  clk,
   input  wire                  rst,
   // APB configuration port
   input  wire                  psel,
   input  wire                  penable,
   input  wire                  pwrite,
   input  wire [7:0]            paddr,
   input  wire [DATA_W-1:0]     pwdata,
   output logic [DATA_W-1:0]    prdata,
   output logic                 pready,
   output logic                 pslverr,
   // External data bus
   output logic                 bus_valid,
   output lut_pkg::io_addr_t    bus_addr,
   output lut_pkg::burst_len_t  bus_len,
   input  wire [DATA_W-1:0]     bus_rdata,
   input  wire                  bus_ready,
   input  wire                  bus_last,
   // Lookup stream
   input  wire [ADDR_W-1:0]     key,
   output logic [DATA_W-1:0]    value
);

   import lut_pkg::*;

   logic              run;
   logic              ping_pong;
   logic              done;
   io_addr_t          ext_addr;
   burst_len_t        length;
   logic [ADDR_W-1:0] iterations;
   period_t           period;
   period_t           duty;
   logic [ADDR_W-1:0] shift;
   logic [ADDR_W-1:0] incr;
   logic [ADDR_W-1:0] rd_addr;
   logic [ADDR_W-1:0] wr_addr;
   logic              wr_en;
   logic [DATA_W-1:0] wr_data;

   lut_apb_regs #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_regs (
      .clk(clk), .rst(rst),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .done(done), .run(run), .ping_pong(ping_pong), .ext_addr(ext_addr),
      .length(length), .iterations(iterations), .period(period),
      .duty(duty), .shift(shift), .incr(incr)
   );

   lut_read_unit #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_read (
      .clk(clk), .rst(rst), .run(run), .ping_pong(ping_pong),
      .ext_addr(ext_addr), .length(length), .iterations(iterations),
      .period(period), .duty(duty), .shift(shift), .incr(incr),
      .key(key),
      .bus_valid(bus_valid), .bus_addr(bus_addr), .bus_len(bus_len),
      .bus_rdata(bus_rdata), .bus_ready(bus_ready), .bus_last(bus_last),
      .rd_addr(rd_addr), .wr_addr(wr_addr), .wr_en(wr_en),
      .wr_data(wr_data), .done(done)
   );

   lut_dp_ram #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) u_ram (
      .clk(clk),
      .rd_addr(rd_addr),
      .wr_en(wr_en),
      .wr_addr(wr_addr),
      .wr_data(wr_data),
      .rd_data(value)
   );

endmodule

`default_nettype wire

/* sim.f */
hw/lut_pkg.sv
hw/lut_addr_gen.sv
hw/lut_mem_writer.sv
hw/lut_dp_ram.sv
hw/lut_read_unit.sv
hw/lut_apb_regs.sv
hw/lut_top.sv
verif/lut_bus_model.sv
verif/lut_tb.sv

/* verif/lut_bus_model.sv */
`default_nettype none

module lut_bus_model #(
   parameter int DATA_W = 32
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  stall,
   input  wire                  bus_valid,
   input  lut_pkg::io_addr_t    bus_addr,
   input  lut_pkg::burst_len_t  bus_len,
   output logic [DATA_W-1:0]    bus_rdata,
   output logic                 bus_ready,
   output logic                 bus_last
);

   import lut_pkg::*;

   integer     seed;
   logic       active;
   io_addr_t   addr_q;
   burst_len_t len_q;
   burst_len_t beat;
   io_addr_t   base;
   burst_len_t cur_len;

   initial seed = 32'h8ba8;

   // First cycle of a burst uses the live request
   assign base      = active ? addr_q : bus_addr;
   assign cur_len   = active ? len_q : bus_len;
   assign bus_rdata = base + beat;
   assign bus_last  = (beat == cur_len - 8'd1);

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         active <= 1'b0;
         addr_q <= '0;
         len_q  <= '0;
         beat   <= '0;
      end else begin
         if (bus_valid && !active) begin
            active <= 1'b1;
            addr_q <= bus_addr;
            len_q  <= bus_len;
         end
         if (bus_valid && bus_ready) begin
            if (bus_last) begin
               active <= 1'b0;
               beat   <= '0;
            end else begin
               beat <= beat + 8'd1;
            end
         end
      end
   end

   // Back-pressure on roughly one cycle in four
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         bus_ready <= 1'b0;
      end else if (stall) begin
         bus_ready <= ({$random(seed)} % 4) != 0;
      end else begin
         bus_ready <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* verif/lut_tb.sv */
`default_nettype none

module lut_tb;

   import lut_pkg::*;

   localparam int DATA_W       = 32;
   localparam int ADDR_W       = 8;
   localparam int ROWS         = 6;
   localparam int RESET_CYCLES = 16;

   logic              clk = 1'b0;
   logic              rst;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [7:0]        paddr;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic              bus_valid;
   io_addr_t          bus_addr;
   burst_len_t        bus_len;
   logic [DATA_W-1:0] bus_rdata;
   logic              bus_ready;
   logic              bus_last;
   logic [ADDR_W-1:0] key;
   logic [DATA_W-1:0] value;
   logic              stall;

   // Test table, one entry per load
   logic [31:0]       row_ext   [ROWS];
   int                row_iter  [ROWS];
   int                row_per   [ROWS];
   int                row_duty  [ROWS];
   int                row_shift [ROWS];
   int                row_incr  [ROWS];
   int                row_pp    [ROWS];
   int                row_stall [ROWS];
   int                row_nkeys [ROWS];
   logic [63:0]       row_keys  [ROWS];
   int                num_rows;

   // Reference table and bank
   logic [DATA_W-1:0] ref_mem   [2**ADDR_W];
   logic              ref_known [2**ADDR_W];
   logic              ref_bank;

   int                errors;
   int                beats = 0;

   always #50 clk = ~clk;

   lut_top #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) dut (
      .clk(clk), .rst(rst),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .bus_valid(bus_valid), .bus_addr(bus_addr), .bus_len(bus_len),
      .bus_rdata(bus_rdata), .bus_ready(bus_ready), .bus_last(bus_last),
      .key(key), .value(value)
   );

   lut_bus_model #(
      .DATA_W(DATA_W)
   ) u_bus (
      .clk(clk), .rst(rst), .stall(stall),
      .bus_valid(bus_valid), .bus_addr(bus_addr), .bus_len(bus_len),
      .bus_rdata(bus_rdata), .bus_ready(bus_ready), .bus_last(bus_last)
   );

   // Bus transfer counter
   always @(posedge clk) begin
      if (!rst && bus_valid && bus_ready) begin
         beats <= beats + 1;
      end
   end

   task automatic stop_run();
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      // Mid access cycle
      @(negedge clk);
      data = prdata;
      err  = pslverr;
      compare("pready", pready, 1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic add_row(input logic [31:0] ext, input int iter, input int per,
                          input int duty, input int shift, input int incr,
                          input int pp, input int stl, input int nkeys,
                          input logic [63:0] keys);
      row_ext[num_rows]   = ext;
      row_iter[num_rows]  = iter;
      row_per[num_rows]   = per;
      row_duty[num_rows]  = duty;
      row_shift[num_rows] = shift;
      row_incr[num_rows]  = incr;
      row_pp[num_rows]    = pp;
      row_stall[num_rows] = stl;
      row_nkeys[num_rows] = nkeys;
      row_keys[num_rows]  = keys;
      num_rows++;
   endtask

   task automatic fill_table();
      // ext, iter, per, duty, shift, incr, ping_pong, stall, key count, keys (key 0 lowest)
      add_row(32'h0000_1000, 4, 32, 32, 0, 1, 0, 0, 4, 64'h0000_0000_FFC5_8180);
      add_row(32'h0000_2000, 3, 6, 4, 3, 2, 0, 0, 7, 64'h00A4_908F_8882_8180);
      add_row(32'h0000_3000, 2, 8, 8, 0, 1, 1, 0, 5, 64'h0000_0010_0100_8F80);
      add_row(32'h0000_4000, 1, 8, 8, 0, 1, 1, 0, 5, 64'h0000_000F_0088_8780);
      add_row(32'h0000_5000, 5, 7, 5, 1, 3, 0, 0, 6, 64'h0000_F0E4_968F_8380);
      add_row(32'h0000_6000, 5, 7, 5, 1, 3, 0, 1, 6, 64'h0000_F0E4_968F_8380);
   endtask

   // Walks the address rule and writes the idle bank of the reference
   task automatic build_reference(input int r, output int len);
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] wa;
      int                beat;
      a        = '0;
      beat     = 0;
      ref_bank = row_pp[r] ? !ref_bank : 1'b0;
      for (int i = 0; i < row_iter[r]; i++) begin
         for (int s = 0; s < row_per[r]; s++) begin
            if (s < row_duty[r]) begin
               wa = {a[ADDR_W-1] ^ !ref_bank, a[ADDR_W-2:0]};
               ref_mem[wa]   = row_ext[r] + beat;
               ref_known[wa] = 1'b1;
               beat++;
            end
            a = a + row_incr[r];
         end
         a = a + row_shift[r];
      end
      len = row_iter[r] * ((row_duty[r] < row_per[r]) ? row_duty[r] : row_per[r]);
   endtask

   task automatic check_registers();
      logic [7:0]  offs [7];
      logic [31:0] vals [7];
      logic [31:0] rd;
      logic        err;
      offs = '{REG_EXT_ADDR, REG_ITER, REG_PER, REG_DUTY, REG_SHIFT, REG_INCR, REG_LENGTH};
      vals = '{32'hA5C3_1E07, 32'h5A, 32'h2B7, 32'h155, 32'hC3, 32'h3C, 32'h96};
      apb_read(REG_STATUS, rd, err);
      compare("status.done", rd[0], 1);
      compare("pslverr", err, 0);
      // Run bit reads back as zero
      // Config is still all zero here, so this run is an empty load
      apb_write(REG_CTRL, 32'h3);
      apb_read(REG_CTRL, rd, err);
      compare("prdata[ctrl]", rd, 32'h2);
      apb_write(REG_CTRL, 32'h0);
      apb_read(REG_CTRL, rd, err);
      compare("prdata[ctrl]", rd, 32'h0);
      for (int i = 0; i < 7; i++) begin
         apb_write(offs[i], vals[i]);
      end
      for (int i = 0; i < 7; i++) begin
         apb_read(offs[i], rd, err);
         compare($sformatf("prdata[%h]", offs[i]), rd, vals[i]);
         compare("pslverr", err, 0);
      end
      apb_read(8'h24, rd, err);
      compare("pslverr[24]", err, 1);
      apb_read(8'h44, rd, err);
      compare("pslverr[44]", err, 1);
   endtask

   task automatic lookup_keys(input int r);
      logic [ADDR_W-1:0] k;
      logic [ADDR_W-1:0] ra;
      logic [DATA_W-1:0] exp_q [$];
      int                n;
      n = row_nkeys[r];
      for (int j = 0; j < n + 2; j++) begin
         @(posedge clk);
         if (j < n) begin
            k  = row_keys[r][ADDR_W*j +: ADDR_W];
            ra = {k[ADDR_W-1] ^ ref_bank, k[ADDR_W-2:0]};
            if (!ref_known[ra]) begin
               $display("ERROR: row %0d key %h reads an entry that no load has written",
                        r, k);
               stop_run();
            end
            exp_q.push_back(ref_mem[ra]);
            key <= k;
         end
         // Value of the key driven two edges back
         @(negedge clk);
         if (j >= 2) begin
            compare("value", value, exp_q.pop_front());
         end
      end
   endtask

   task automatic run_row(input int r);
      int          len;
      int          start_beats;
      logic [31:0] rd;
      logic        err;
      build_reference(r, len);
      apb_write(REG_EXT_ADDR, row_ext[r]);
      apb_write(REG_ITER, row_iter[r]);
      apb_write(REG_PER, row_per[r]);
      apb_write(REG_DUTY, row_duty[r]);
      apb_write(REG_SHIFT, row_shift[r]);
      apb_write(REG_INCR, row_incr[r]);
      apb_write(REG_LENGTH, len);
      @(posedge clk);
      stall <= row_stall[r][0];
      start_beats = beats;
      apb_write(REG_CTRL, (row_pp[r] << 1) | 1);
      apb_read(REG_STATUS, rd, err);
      compare("status.done after run", rd[0], 0);
      while (!rd[0]) begin
         apb_read(REG_STATUS, rd, err);
      end
      @(negedge clk);
      compare("bus beats", beats - start_beats, len);
      compare("bus_valid", bus_valid, 0);
      compare("bus_addr", bus_addr, row_ext[r]);
      compare("bus_len", bus_len, len);
      lookup_keys(r);
   endtask

   initial begin
      repeat (RESET_CYCLES + ROWS * 2000) @(posedge clk);
      $display("ERROR: watchdog expired, the run hung waiting for done");
      stop_run();
   end

   initial begin
      rst      = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      key      = '0;
      stall    = 1'b0;
      errors   = 0;
      num_rows = 0;
      ref_bank = 1'b0;
      for (int i = 0; i < 2**ADDR_W; i++) begin
         ref_known[i] = 1'b0;
      end
      fill_table();
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      check_registers();
      for (int r = 0; r < num_rows; r++) begin
         run_row(r);
      end
      if (errors == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         stop_run();
      end
   end

endmodule

`default_nettype wire
